// ==== src/noc_adapter_pkg.sv ====
`default_nettype none

package noc_adapter_pkg;

    // Default configuration of the adapter
    parameter int DEF_DATA_WIDTH       = 32;  // One word per flit
    parameter int DEF_COORD_WIDTH      = 4;   // Per mesh coordinate
    parameter int DEF_NUM_VCS          = 4;
    parameter int DEF_TX_FIFO_DEPTH    = 16;
    parameter int DEF_RX_FIFO_DEPTH    = 16;
    parameter int DEF_CREDITS_PER_VC   = 4;
    parameter int DEF_MAX_PACKET_FLITS = 4;

    // Bits needed to index n items, never less than one
    function automatic int idx_width(input int n);
        if (n > 1) begin
            return $clog2(n);
        end
        return 1;
    endfunction

    // Bits needed to hold a count from 0 up to and including n
    function automatic int cnt_width(input int n);
        if (n > 0) begin
            return $clog2(n + 1);
        end
        return 1;
    endfunction

    // Destination is two coordinates, y above x
    function automatic int dest_width(input int coord_w);
        return 2 * coord_w;
    endfunction

endpackage

`default_nettype wire

// ==== src/stream_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_fifo
    import noc_adapter_pkg::*;
#(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             wr_valid,
    input  wire logic [WIDTH-1:0] wr_data,
    output logic                  wr_ready,
    output logic                  rd_valid,
    output logic [WIDTH-1:0]      rd_data,
    input  wire logic             rd_ready
);

    localparam int PTR_W = idx_width(DEPTH);
    localparam int CNT_W = cnt_width(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;  // Entries held, 0..DEPTH

    logic wr_en;
    logic rd_en;

    assign wr_ready = (count != CNT_W'(DEPTH));
    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];  // First word falls through

    assign wr_en = wr_valid && wr_ready;
    assign rd_en = rd_valid && rd_ready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                // Wrap by compare, so DEPTH need not be a power of two
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/vc_credit_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module vc_credit_table
    import noc_adapter_pkg::*;
#(
    parameter int NUM_VCS        = 4,
    parameter int CREDITS_PER_VC = 4
) (
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire logic                          spend,
    input  wire logic [idx_width(NUM_VCS)-1:0] spend_vc,
    input  wire logic                          credit_in,
    input  wire logic [idx_width(NUM_VCS)-1:0] credit_in_vc,
    input  wire logic [idx_width(NUM_VCS)-1:0] query_vc,
    output logic                               credit_avail
);

    localparam int VC_W  = idx_width(NUM_VCS);
    localparam int CRD_W = cnt_width(CREDITS_PER_VC);

    // Free slots in the router input buffer, one counter per VC
    logic [CRD_W-1:0] credits [NUM_VCS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_VCS; i++) begin
                credits[i] <= CRD_W'(CREDITS_PER_VC);
            end
        end else begin
            for (int i = 0; i < NUM_VCS; i++) begin
                case ({spend && (spend_vc == VC_W'(i)),
                       credit_in && (credit_in_vc == VC_W'(i))})
                    2'b10:   credits[i] <= credits[i] - 1'b1;  // Flit sent
                    2'b01:   credits[i] <= credits[i] + 1'b1;  // Slot freed downstream
                    default: credits[i] <= credits[i];
                endcase
            end
        end
    end

    // Level seen by the packer for its current VC
    assign credit_avail = (credits[query_vc] != '0);

endmodule

`default_nettype wire

// ==== src/flit_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

module flit_packer
    import noc_adapter_pkg::*;
#(
    parameter int DATA_WIDTH       = 32,
    parameter int COORD_WIDTH      = 4,
    parameter int NUM_VCS          = 4,
    parameter int MAX_PACKET_FLITS = 4
) (
    input  wire logic                                clk,
    input  wire logic                                reset,

    // Head of the transmit FIFO
    input  wire logic                                in_valid,
    input  wire logic [DATA_WIDTH-1:0]               in_data,
    input  wire logic                                in_last,
    input  wire logic [dest_width(COORD_WIDTH)-1:0]  in_dest,
    output logic                                     in_ready,

    // Credit table
    input  wire logic                                credit_avail,
    output logic                                     spend,
    output logic [idx_width(NUM_VCS)-1:0]            cur_vc,

    // Flits toward the router
    output logic                                     flit_out_valid,
    output logic [idx_width(NUM_VCS)-1:0]            flit_out_vc,
    output logic                                     flit_out_head,
    output logic                                     flit_out_tail,
    output logic [dest_width(COORD_WIDTH)-1:0]       flit_out_dest,
    output logic [DATA_WIDTH-1:0]                    flit_out_data
);

    localparam int VC_W   = idx_width(NUM_VCS);
    localparam int CNT_W  = cnt_width(MAX_PACKET_FLITS);

    logic             in_packet;  // Head already sent on cur_vc
    logic [CNT_W-1:0] flit_cnt;   // Flits sent so far in this packet
    logic             pop;
    logic             is_tail;

    // Pop whenever the current VC has room downstream
    assign in_ready = credit_avail;
    assign pop      = in_valid && credit_avail;
    assign spend    = pop;

    // Tail on tlast, or when the packet reaches its flit limit
    assign is_tail = in_last || (flit_cnt == CNT_W'(MAX_PACKET_FLITS - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flit_out_valid <= 1'b0;
            in_packet      <= 1'b0;
            flit_cnt       <= '0;
            cur_vc         <= '0;
        end else begin
            flit_out_valid <= pop;
            if (pop) begin
                if (is_tail) begin
                    in_packet <= 1'b0;
                    flit_cnt  <= '0;
                    // Round-robin, one VC per packet
                    cur_vc    <= (cur_vc == VC_W'(NUM_VCS - 1)) ? '0 : cur_vc + 1'b1;
                end else begin
                    in_packet <= 1'b1;
                    flit_cnt  <= flit_cnt + 1'b1;
                end
            end
        end
    end

    // Flit fields, qualified by flit_out_valid
    always_ff @(posedge clk) begin
        if (pop) begin
            flit_out_vc   <= cur_vc;
            flit_out_head <= !in_packet;
            flit_out_tail <= is_tail;
            flit_out_dest <= in_packet ? '0 : in_dest;  // Body flits carry no route
            flit_out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

// ==== src/flit_unpacker.sv ====
`timescale 1ns/1ps
`default_nettype none

module flit_unpacker
    import noc_adapter_pkg::*;
#(
    parameter int DATA_WIDTH  = 32,
    parameter int COORD_WIDTH = 4,
    parameter int NUM_VCS     = 4
) (
    input  wire logic                                clk,
    input  wire logic                                reset,

    // Flits from the router
    input  wire logic                                flit_in_valid,
    input  wire logic [idx_width(NUM_VCS)-1:0]       flit_in_vc,
    input  wire logic                                flit_in_head,
    input  wire logic                                flit_in_tail,
    input  wire logic [dest_width(COORD_WIDTH)-1:0]  flit_in_dest,
    input  wire logic [DATA_WIDTH-1:0]               flit_in_data,

    // Receive FIFO write side
    output logic                                     wr_valid,
    output logic [DATA_WIDTH-1:0]                    wr_data,
    output logic                                     wr_last,
    output logic [dest_width(COORD_WIDTH)-1:0]       wr_dest,
    output logic [idx_width(NUM_VCS)-1:0]            wr_vc,

    output logic                                     rx_frame_error
);

    localparam int DEST_W = dest_width(COORD_WIDTH);

    logic              in_packet;
    logic [DEST_W-1:0] dest_hold;  // Route of the open packet
    logic              accept;
    logic              orphan;

    // A head always opens a packet; a body needs one open
    assign accept = flit_in_valid && (flit_in_head || in_packet);
    assign orphan = flit_in_valid && !flit_in_head && !in_packet;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_valid       <= 1'b0;
            in_packet      <= 1'b0;
            rx_frame_error <= 1'b0;
        end else begin
            wr_valid <= accept;
            if (accept) begin
                in_packet <= !flit_in_tail;
            end
            if (orphan) begin
                rx_frame_error <= 1'b1;  // Sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && flit_in_head) begin
            dest_hold <= flit_in_dest;
        end
        if (accept) begin
            wr_data <= flit_in_data;
            wr_last <= flit_in_tail;
            wr_dest <= flit_in_head ? flit_in_dest : dest_hold;
            wr_vc   <= flit_in_vc;
        end
    end

endmodule

`default_nettype wire

// ==== src/noc_stream_adapter.sv ====
`timescale 1ns/1ps
`default_nettype none

module noc_stream_adapter
    import noc_adapter_pkg::*;
#(
    parameter int DATA_WIDTH       = DEF_DATA_WIDTH,
    parameter int COORD_WIDTH      = DEF_COORD_WIDTH,
    parameter int NUM_VCS          = DEF_NUM_VCS,
    parameter int TX_FIFO_DEPTH    = DEF_TX_FIFO_DEPTH,
    parameter int RX_FIFO_DEPTH    = DEF_RX_FIFO_DEPTH,
    parameter int CREDITS_PER_VC   = DEF_CREDITS_PER_VC,
    parameter int MAX_PACKET_FLITS = DEF_MAX_PACKET_FLITS
) (
    input  wire logic                                clk,
    input  wire logic                                reset,

    // Slave stream from the source
    input  wire logic                                slave_tvalid,
    input  wire logic [DATA_WIDTH-1:0]               slave_tdata,
    input  wire logic                                slave_tlast,
    input  wire logic [dest_width(COORD_WIDTH)-1:0]  slave_tdest,
    output logic                                     slave_tready,

    // Master stream to the sink
    output logic                                     master_tvalid,
    output logic [DATA_WIDTH-1:0]                    master_tdata,
    output logic                                     master_tlast,
    output logic [dest_width(COORD_WIDTH)-1:0]       master_tdest,
    input  wire logic                                master_tready,

    // Injection link into the router
    output logic                                     flit_out_valid,
    output logic [idx_width(NUM_VCS)-1:0]            flit_out_vc,
    output logic                                     flit_out_head,
    output logic                                     flit_out_tail,
    output logic [dest_width(COORD_WIDTH)-1:0]       flit_out_dest,
    output logic [DATA_WIDTH-1:0]                    flit_out_data,

    // Ejection link from the router
    input  wire logic                                flit_in_valid,
    input  wire logic [idx_width(NUM_VCS)-1:0]       flit_in_vc,
    input  wire logic                                flit_in_head,
    input  wire logic                                flit_in_tail,
    input  wire logic [dest_width(COORD_WIDTH)-1:0]  flit_in_dest,
    input  wire logic [DATA_WIDTH-1:0]               flit_in_data,

    // Credits
    input  wire logic                                credit_in,
    input  wire logic [idx_width(NUM_VCS)-1:0]       credit_in_vc,
    output logic                                     credit_out,
    output logic [idx_width(NUM_VCS)-1:0]            credit_out_vc,

    output logic                                     rx_frame_error
);

    localparam int DEST_W = dest_width(COORD_WIDTH);
    localparam int VC_W   = idx_width(NUM_VCS);
    localparam int TX_W   = DATA_WIDTH + 1 + DEST_W;         // {data, last, dest}
    localparam int RX_W   = DATA_WIDTH + 1 + DEST_W + VC_W;  // {data, last, dest, vc}

    logic                  tx_valid;
    logic [TX_W-1:0]       tx_entry;
    logic                  tx_ready;
    logic                  credit_avail;
    logic                  spend;
    logic [VC_W-1:0]       cur_vc;

    logic                  rx_wr_valid;
    logic [DATA_WIDTH-1:0] rx_wr_data;
    logic                  rx_wr_last;
    logic [DEST_W-1:0]     rx_wr_dest;
    logic [VC_W-1:0]       rx_wr_vc;
    logic [RX_W-1:0]       rx_entry;
    logic [VC_W-1:0]       rx_vc;

    stream_fifo #(
        .WIDTH (TX_W),
        .DEPTH (TX_FIFO_DEPTH)
    ) u_tx_fifo (
        .clk      (clk),
        .reset    (reset),
        .wr_valid (slave_tvalid),
        .wr_data  ({slave_tdata, slave_tlast, slave_tdest}),
        .wr_ready (slave_tready),  // Low only while full
        .rd_valid (tx_valid),
        .rd_data  (tx_entry),
        .rd_ready (tx_ready)
    );

    vc_credit_table #(
        .NUM_VCS        (NUM_VCS),
        .CREDITS_PER_VC (CREDITS_PER_VC)
    ) u_vc_credit_table (
        .clk          (clk),
        .reset        (reset),
        .spend        (spend),
        .spend_vc     (cur_vc),
        .credit_in    (credit_in),
        .credit_in_vc (credit_in_vc),
        .query_vc     (cur_vc),
        .credit_avail (credit_avail)
    );

    flit_packer #(
        .DATA_WIDTH       (DATA_WIDTH),
        .COORD_WIDTH      (COORD_WIDTH),
        .NUM_VCS          (NUM_VCS),
        .MAX_PACKET_FLITS (MAX_PACKET_FLITS)
    ) u_flit_packer (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (tx_valid),
        .in_data        (tx_entry[TX_W-1 -: DATA_WIDTH]),
        .in_last        (tx_entry[DEST_W]),
        .in_dest        (tx_entry[DEST_W-1:0]),
        .in_ready       (tx_ready),
        .credit_avail   (credit_avail),
        .spend          (spend),
        .cur_vc         (cur_vc),
        .flit_out_valid (flit_out_valid),
        .flit_out_vc    (flit_out_vc),
        .flit_out_head  (flit_out_head),
        .flit_out_tail  (flit_out_tail),
        .flit_out_dest  (flit_out_dest),
        .flit_out_data  (flit_out_data)
    );

    flit_unpacker #(
        .DATA_WIDTH  (DATA_WIDTH),
        .COORD_WIDTH (COORD_WIDTH),
        .NUM_VCS     (NUM_VCS)
    ) u_flit_unpacker (
        .clk            (clk),
        .reset          (reset),
        .flit_in_valid  (flit_in_valid),
        .flit_in_vc     (flit_in_vc),
        .flit_in_head   (flit_in_head),
        .flit_in_tail   (flit_in_tail),
        .flit_in_dest   (flit_in_dest),
        .flit_in_data   (flit_in_data),
        .wr_valid       (rx_wr_valid),
        .wr_data        (rx_wr_data),
        .wr_last        (rx_wr_last),
        .wr_dest        (rx_wr_dest),
        .wr_vc          (rx_wr_vc),
        .rx_frame_error (rx_frame_error)
    );

    // Space is guaranteed by the credits, so write ready is left open
    stream_fifo #(
        .WIDTH (RX_W),
        .DEPTH (RX_FIFO_DEPTH)
    ) u_rx_fifo (
        .clk      (clk),
        .reset    (reset),
        .wr_valid (rx_wr_valid),
        .wr_data  ({rx_wr_data, rx_wr_last, rx_wr_dest, rx_wr_vc}),
        .wr_ready (),
        .rd_valid (master_tvalid),
        .rd_data  (rx_entry),
        .rd_ready (master_tready)
    );

    assign master_tdata = rx_entry[RX_W-1 -: DATA_WIDTH];
    assign master_tlast = rx_entry[DEST_W + VC_W];
    assign master_tdest = rx_entry[VC_W +: DEST_W];
    assign rx_vc        = rx_entry[VC_W-1:0];

    // One credit back per beat drained, on the VC the flit came in on
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credit_out <= 1'b0;
        end else begin
            credit_out <= master_tvalid && master_tready;
        end
    end

    always_ff @(posedge clk) begin
        if (master_tvalid && master_tready) begin
            credit_out_vc <= rx_vc;
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_noc_stream_adapter.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_noc_stream_adapter;

    localparam int DW       = 32;
    localparam int DEST_W   = 8;   // Two 4-bit mesh coordinates
    localparam int VW       = 2;
    localparam int NVC      = 4;
    localparam int DEPTH    = 16;
    localparam int CRED     = 4;
    localparam int MAXF     = 4;
    localparam int NUM_PKTS = 20;  // Random transmit packets, 1 to 10 beats
    localparam int RX_FLITS = 60;
    // Worst-case beat count, 24 cycles per beat, plus credit hold and margin
    localparam int TIMEOUT  = (1 + NUM_PKTS * 10 + 40 + RX_FLITS + 2) * 24 + 600;

    logic              clk, reset;
    logic              slave_tvalid, slave_tready, slave_tlast;
    logic              master_tvalid, master_tlast;
    logic              flit_out_valid, flit_out_head, flit_out_tail;
    logic              flit_in_valid, flit_in_head, flit_in_tail;
    logic              credit_out, rx_frame_error;
    logic [DW-1:0]     slave_tdata, master_tdata, flit_out_data, flit_in_data;
    logic [DEST_W-1:0] slave_tdest, master_tdest, flit_out_dest, flit_in_dest;
    logic [VW-1:0]     flit_out_vc, flit_in_vc, credit_out_vc;
    logic              master_tready = 1'b1;
    logic              credit_in = 1'b0;
    logic [VW-1:0]     credit_in_vc = '0;

    logic [VW+2+DEST_W+DW-1:0] exp_flit[$];  // {vc, head, tail, dest, data}
    logic [DEST_W+DW:0]        exp_beat[$];  // {last, dest, data}

    int                seed = 32'h984b;
    int                seq_errors, mon_errors, cycles, tests_run, mark;
    int                flits_seen[NVC], credits_given[NVC];
    int                rx_sent[NVC], rx_credited[NVC], rx_total, rx_back;
    bit                hold_credits, random_ready, rx_open, err_seen;
    logic [VW-1:0]     exp_vc;
    logic [DEST_W-1:0] rx_dest;

    noc_stream_adapter #(
        .DATA_WIDTH       (DW),
        .COORD_WIDTH      (DEST_W / 2),
        .NUM_VCS          (NVC),
        .TX_FIFO_DEPTH    (DEPTH),
        .RX_FIFO_DEPTH    (DEPTH),
        .CREDITS_PER_VC   (CRED),
        .MAX_PACKET_FLITS (MAXF)
    ) u_noc_stream_adapter (.*);

    // One on a mismatch, so callers add it to their own count
    function automatic int mismatch(input string name, input logic [63:0] got, want);
        int bad;
        bad = (got != want) ? 1 : 0;
        assert (bad == 0) else $display("MISMATCH %s: got %0h, expected %0h", name, got, want);
        return bad;
    endfunction

    // Expected flits follow the packing rules, then the beats go out
    task automatic send_packet(input int beats, input logic [DEST_W-1:0] dest);
        logic [DW-1:0] data;
        logic          head;
        logic          tail;
        int            cnt;
        bit            taken;
        cnt = 0;
        for (int i = 0; i < beats; i++) begin
            data = $random(seed);
            head = (cnt == 0);
            tail = (i == beats - 1) || (cnt == MAXF - 1);
            exp_flit.push_back({exp_vc, head, tail, head ? dest : {DEST_W{1'b0}}, data});
            if (tail) begin
                cnt    = 0;
                exp_vc = VW'((exp_vc + 1) % NVC);  // Next packet on the next VC
            end else begin
                cnt++;
            end
            slave_tvalid = 1'b1;
            slave_tdata  = data;
            slave_tlast  = (i == beats - 1);
            slave_tdest  = dest;
            do begin
                taken = slave_tready;  // Stable until the next rising edge
                @(negedge clk);
            end while (!taken);
        end
        slave_tvalid = 1'b0;
    endtask

    // Router side of the ejection link
    task automatic send_flit(input logic [VW-1:0] vc, input logic head, tail,
                             input logic [DEST_W-1:0] dest);
        logic [DW-1:0] data;
        data = $random(seed);
        while (rx_total - rx_back >= DEPTH) begin
            @(negedge clk);
        end
        flit_in_valid = 1'b1;
        flit_in_vc    = vc;
        flit_in_head  = head;
        flit_in_tail  = tail;
        flit_in_dest  = dest;
        flit_in_data  = data;
        if (head || rx_open) begin  // An orphan body is dropped and never credited
            if (head) begin
                rx_dest = dest;
            end
            exp_beat.push_back({tail, rx_dest, data});
            rx_open = !tail;
            rx_sent[vc]++;
            rx_total++;
        end
        @(negedge clk);
        flit_in_valid = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_flit.size() != 0 || exp_beat.size() != 0 || rx_total != rx_back) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("%0d %s: %s", tests_run, name,
                 (seq_errors + mon_errors == mark) ? "pass" : "fail");
        mark = seq_errors + mon_errors;
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("Timeout after %0d cycles with traffic still pending", TIMEOUT);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Flit and beat scoreboards, sampled on the rising edge
    always @(posedge clk) begin : monitor
        logic [VW+2+DEST_W+DW-1:0] f;
        logic [DEST_W+DW:0]        b;
        if (!reset && flit_out_valid) begin
            assert (exp_flit.size() != 0) else begin
                $display("Flit on VC %0d with no beat behind it", flit_out_vc);
                mon_errors++;
            end
            if (exp_flit.size() != 0) begin
                f = exp_flit.pop_front();
                mon_errors += mismatch("flit_out_data", 64'(flit_out_data), 64'(f[DW-1:0]));
                mon_errors += mismatch("flit_out_dest", 64'(flit_out_dest),
                                       64'(f[DW +: DEST_W]));
                mon_errors += mismatch("flit_out_tail", 64'(flit_out_tail), 64'(f[DW+DEST_W]));
                mon_errors += mismatch("flit_out_head", 64'(flit_out_head),
                                       64'(f[DW+DEST_W+1]));
                mon_errors += mismatch("flit_out_vc", 64'(flit_out_vc),
                                       64'(f[DW+DEST_W+2 +: VW]));
            end
            flits_seen[flit_out_vc]++;
            assert (flits_seen[flit_out_vc] - credits_given[flit_out_vc] <= CRED) else begin
                $display("More than %0d flits outstanding on VC %0d", CRED, flit_out_vc);
                mon_errors++;
            end
        end
        if (!reset && master_tvalid && master_tready) begin
            assert (exp_beat.size() != 0) else begin
                $display("Master beat with no accepted flit behind it");
                mon_errors++;
            end
            if (exp_beat.size() != 0) begin
                b = exp_beat.pop_front();
                mon_errors += mismatch("master_tdata", 64'(master_tdata), 64'(b[DW-1:0]));
                mon_errors += mismatch("master_tdest", 64'(master_tdest), 64'(b[DW +: DEST_W]));
                mon_errors += mismatch("master_tlast", 64'(master_tlast), 64'(b[DW+DEST_W]));
            end
        end
        if (!reset && credit_out) begin
            rx_credited[credit_out_vc]++;
            rx_back++;
        end
        if (!reset && err_seen) begin
            assert (rx_frame_error) else begin
                $display("rx_frame_error dropped without a reset");
                mon_errors++;
            end
        end
        err_seen = rx_frame_error;
    end

    // Router credit return after a random delay, and sink ready
    always @(negedge clk) begin : router_credits
        int start;
        int v;
        credit_in     = 1'b0;
        master_tready = random_ready ? 1'($random(seed)) : 1'b1;
        if (!reset && !hold_credits && ($random(seed) % 2 == 0)) begin
            start = ($random(seed) & 32'h7fff) % NVC;
            for (int k = 0; k < NVC; k++) begin
                v = (start + k) % NVC;
                if (!credit_in && flits_seen[v] > credits_given[v]) begin
                    credit_in    = 1'b1;
                    credit_in_vc = VW'(v);
                    credits_given[v]++;
                end
            end
        end
    end

    initial begin : main
        int                len;
        logic [VW-1:0]     vc;
        logic [DEST_W-1:0] dest;
        reset         = 1'b1;
        slave_tvalid  = 1'b0;
        slave_tdata   = '0;
        slave_tlast   = 1'b0;
        slave_tdest   = '0;
        flit_in_valid = 1'b0;
        flit_in_vc    = '0;
        flit_in_head  = 1'b0;
        flit_in_tail  = 1'b0;
        flit_in_dest  = '0;
        flit_in_data  = '0;
        exp_vc        = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;

        seq_errors += mismatch("slave_tready", 64'(slave_tready), 64'(1));
        seq_errors += mismatch("master_tvalid", 64'(master_tvalid), 64'(0));
        seq_errors += mismatch("flit_out_valid", 64'(flit_out_valid), 64'(0));
        seq_errors += mismatch("credit_out", 64'(credit_out), 64'(0));
        seq_errors += mismatch("rx_frame_error", 64'(rx_frame_error), 64'(0));
        end_test("reset values");

        send_packet(1, 8'h5a);
        wait_drained();
        end_test("single beat packet");

        for (int p = 0; p < NUM_PKTS; p++) begin
            send_packet(1 + ($random(seed) & 32'h7fff) % 10, DEST_W'($random(seed)));
        end
        wait_drained();
        end_test("random packets with splits");

        // 40 beats overrun the credits and the transmit FIFO together
        hold_credits = 1'b1;
        fork
            for (int p = 0; p < 8; p++) begin
                send_packet(5, DEST_W'($random(seed)));
            end
            begin
                repeat (80) @(negedge clk);
                hold_credits = 1'b0;
            end
        join
        wait_drained();
        end_test("credits withheld");

        random_ready = 1'b1;
        while (rx_total < RX_FLITS) begin
            len  = 1 + ($random(seed) & 32'h7fff) % 6;
            vc   = VW'($random(seed));
            dest = DEST_W'($random(seed));
            for (int j = 0; j < len; j++) begin
                // Body flits carry junk dest that must not reach master_tdest
                send_flit(vc, j == 0, j == len - 1, (j == 0) ? dest : DEST_W'($random(seed)));
            end
        end
        wait_drained();
        random_ready = 1'b0;
        for (int v = 0; v < NVC; v++) begin
            seq_errors += mismatch($sformatf("credit_out count on VC %0d", v),
                                   64'(rx_credited[v]), 64'(rx_sent[v]));
        end
        end_test("receive path with back-pressure");

        send_flit('0, 1'b0, 1'b0, 8'h33);
        repeat (5) @(negedge clk);
        seq_errors += mismatch("rx_frame_error", 64'(rx_frame_error), 64'(1));
        send_flit(2'd1, 1'b1, 1'b1, 8'h21);
        wait_drained();
        seq_errors += mismatch("rx_frame_error", 64'(rx_frame_error), 64'(1));
        end_test("orphan body flit");

        $display("Tests run %0d, errors %0d", tests_run, seq_errors + mon_errors);
        if (seq_errors + mon_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
src/noc_adapter_pkg.sv
src/stream_fifo.sv
src/vc_credit_table.sv
src/flit_packer.sv
src/flit_unpacker.sv
src/noc_stream_adapter.sv
tb/tb_noc_stream_adapter.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_noc_stream_adapter
FILE_LIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST OK$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
